// File: compile.f
source/ise_pkg.sv
source/ise_packed_alu.sv
source/ise_decoder.sv
source/ise_cpr_file.sv
source/ise_execute.sv
source/ise_top.sv
verif/ise_assertions.sv
verif/tb_ise.sv

// File: Makefile
# Verilator build and run for the ISE coprocessor testbench.

VERILATOR ?= verilator
TOP       ?= tb_ise
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator status is not trusted; the log decides.
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_ise.sv
/* ISE coprocessor testbench */

module tb_ise
    import ise_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DELAY = 2;
    localparam logic [31:0] SEED        = 32'hcfb7e31b;
    // About 470 instructions, half the cycles lost to stalls, plus margin.
    localparam int          CYCLE_LIMIT = 4000;

    logic        g_clk;
    logic        ISE_RESET_CPRS;
    ise_insn_t   insn;
    logic        insn_valid;
    logic        insn_ready;
    ise_resp_t   resp;
    logic        resp_valid;
    logic        resp_ready;

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    ise_word_t   ref_cprs [ISE_NUM_CPRS];
    ise_resp_t   exp_q [$];
    string       name_q [$];
    int          gap_rate;
    logic        backpressure;
    int          sent_count;
    int          resp_count;
    int          cycle_count;

    ise_top ise_top_inst (
        .g_clk          (g_clk),
        .ISE_RESET_CPRS (ISE_RESET_CPRS),
        .insn           (insn),
        .insn_valid     (insn_valid),
        .insn_ready     (insn_ready),
        .resp           (resp),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready)
    );

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // ------------------------------
    // Helpers.
    // ------------------------------

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Fields may overlap; callers keep them consistent.
    function automatic ise_word_t make_enc(ise_funct_t funct, ise_pw_code_t pw,
                                           logic [4:0] rd, ise_cpr_addr_t crs1,
                                           ise_cpr_addr_t crs2, ise_imm16_t imm);
        ise_word_t enc;
        enc        = {funct, imm, 5'd0, ISE_OPCODE};
        enc[11:7]  = rd;
        enc[18:15] = enc[18:15] | crs1;
        enc[23:20] = enc[23:20] | crs2;
        enc[24]    = enc[24] | pw[2];
        enc[19]    = enc[19] | pw[1];
        enc[11]    = enc[11] | pw[0];
        return enc;
    endfunction

    function automatic ise_word_t load_enc(ise_cpr_addr_t c);
        return make_enc(FN_MV2COP, PW_32, {1'b0, c}, 4'd0, 4'd0, 16'd0);
    endfunction

    function automatic ise_word_t readback_enc(ise_cpr_addr_t c);
        return make_enc(FN_MV2GPR, PW_32, {1'b0, c}, c, 4'd0, 16'd0);
    endfunction

    // ------------------------------
    // Reference model.
    // ------------------------------

    function automatic ise_word_t lane_op(ise_funct_t funct, int width,
                                          ise_word_t a, ise_word_t b);
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        ise_word_t   res;
        int          amt;
        mask = (64'd1 << width) - 64'd1;
        amt  = int'(b[4:0]);
        res  = '0;
        for (int lo = 0; lo < 32; lo += width)
        begin
            la = ({32'd0, a} >> lo) & mask;
            lb = ({32'd0, b} >> lo) & mask;
            case (funct)
                FN_ADD_PX: lr = la + lb;
                FN_SUB_PX: lr = la - lb;
                FN_SLL_PX: lr = (amt >= width) ? 64'd0 : (la << amt);
                default:   lr = (amt >= width) ? 64'd0 : (la >> amt);
            endcase
            res = res | 32'((lr & mask) << lo);
        end
        return res;
    endfunction

    function automatic ise_resp_t ref_model(ise_insn_t ins);
        ise_resp_t     r;
        ise_funct_t    funct;
        ise_pw_code_t  pw;
        ise_cpr_addr_t crd;
        ise_word_t     v1;
        ise_word_t     v2;
        ise_word_t     vd;
        logic          is_px;
        funct = ins.enc[31:28];
        pw    = {ins.enc[24], ins.enc[19], ins.enc[11]};
        crd   = ins.enc[10:7];
        v1    = ref_cprs[ins.enc[18:15]];
        v2    = ref_cprs[ins.enc[23:20]];
        vd    = ref_cprs[crd];
        is_px = (funct >= FN_ADD_PX) && (funct <= FN_SRL_PX);
        r     = '0;
        if (ins.enc[6:0] != ISE_OPCODE || funct > FN_LLI || (is_px && pw > PW_2))
        begin
            r.result = RES_DECODE_EXCEPTION;
        end
        else
        begin
            r.result = RES_SUCCESS;
            case (funct)
                FN_MV2GPR:
                begin
                    r.gpr_wen  = 1'b1;
                    r.gpr_addr = ins.enc[11:7];
                    r.gpr_data = v1;
                end
                FN_MV2COP: ref_cprs[crd] = ins.rs1;
                FN_CMOV:   if (v2 == '0) ref_cprs[crd] = v1;
                FN_CMOVN:  if (v2 != '0) ref_cprs[crd] = v1;
                FN_LUI:    ref_cprs[crd] = {ins.enc[27:12], vd[15:0]};
                FN_LLI:    ref_cprs[crd] = {vd[31:16], ins.enc[27:12]};
                default:   ref_cprs[crd] = lane_op(funct, 32 >> pw, v1, v2);
            endcase
        end
        return r;
    endfunction

    // ------------------------------
    // Driver, stalls and checker.
    // ------------------------------

    task automatic send(string name, ise_word_t enc, ise_word_t rs1);
        logic accepted;
        while ((rand_word() % 32'd100) < 32'(gap_rate))
        begin
            insn_valid = 1'b0;
            @(posedge g_clk);
            #DRIVE_DELAY;
        end
        insn.enc   = enc;
        insn.rs1   = rs1;
        insn_valid = 1'b1;
        accepted   = 1'b0;
        while (!accepted)
        begin
            // Handshake is settled by the falling edge.
            @(negedge g_clk);
            accepted = insn_ready;
            if (accepted)
            begin
                exp_q.push_back(ref_model(insn));
                name_q.push_back(name);
                sent_count++;
            end
            @(posedge g_clk);
            #DRIVE_DELAY;
        end
    endtask

    initial
    begin
        logic stall_on;
        resp_ready  = 1'b1;
        ready_state = SEED ^ 32'h5a5a5a5a;
        forever
        begin
            @(posedge g_clk);
            stall_on = backpressure;
            #DRIVE_DELAY;
            ready_state = xorshift(ready_state);
            resp_ready  = !stall_on || (ready_state[1:0] != 2'b00);
        end
    end

    always @(negedge g_clk)
    begin : compare_resp
        ise_resp_t exp_resp;
        string     test_name;
        if (!ISE_RESET_CPRS && resp_valid && resp_ready)
        begin
            assert (exp_q.size() != 0)
            else
                report_failure("A response arrived with no instruction outstanding");
            exp_resp  = exp_q.pop_front();
            test_name = name_q.pop_front();
            assert (resp === exp_resp)
            else
                report_failure($sformatf("Error: test %s expected %h actual %h",
                                         test_name, exp_resp, resp));
            resp_count++;
        end
    end

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge g_clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT)
                report_failure("Timeout: the responses did not all arrive in time");
        end
    end

    // ------------------------------
    // Test sequence.
    // ------------------------------

    initial
    begin
        ise_word_t     enc;
        ise_word_t     opb_val;
        int            width;
        ise_cpr_addr_t ca;
        ise_cpr_addr_t cb;
        ise_cpr_addr_t cd;
        insn           = '0;
        insn_valid     = 1'b0;
        ISE_RESET_CPRS = 1'b1;
        stim_state     = SEED;
        gap_rate       = 0;
        backpressure   = 1'b0;
        sent_count     = 0;
        resp_count     = 0;
        for (int i = 0; i < ISE_NUM_CPRS; i++)
            ref_cprs[i] = '0;
        repeat (2) @(posedge g_clk);
        #DRIVE_DELAY;
        ISE_RESET_CPRS = 1'b0;

        // Every CPR reads zero after reset.
        for (int i = 0; i < ISE_NUM_CPRS; i++)
            send("reset_state", make_enc(FN_MV2GPR, PW_32, 5'(rand_word()), 4'(i),
                                         4'd0, 16'd0), rand_word());

        // Moves and half-word immediates.
        for (int i = 0; i < ISE_NUM_CPRS; i++)
        begin
            cd = 4'(i);
            send("mv2cop", load_enc(cd), rand_word());
            send("lui", make_enc(FN_LUI, PW_32, {1'b0, cd}, 4'd0, 4'd0,
                                 16'(rand_word())), 32'd0);
            send("lui_readback", readback_enc(cd), 32'd0);
            send("lli", make_enc(FN_LLI, PW_32, {1'b0, cd}, 4'd0, 4'd0,
                                 16'(rand_word())), 32'd0);
            send("lli_readback", readback_enc(cd), 32'd0);
        end

        // Packed arithmetic and shifts at every valid width.
        for (int f = 2; f <= 5; f++)
        begin
            for (int p = 0; p <= 4; p++)
            begin
                for (int n = 0; n < 2; n++)
                begin
                    ca      = 4'(rand_word());
                    cb      = 4'(rand_word());
                    cd      = 4'(rand_word());
                    width   = 32 >> p;
                    opb_val = rand_word();
                    // Shifts take one amount inside the lane and one past its edge.
                    if (4'(f) >= FN_SLL_PX)
                    begin
                        if (n == 0)
                            opb_val[4:0] = 5'(rand_word() % 32'(width));
                        else if (width < 32)
                            opb_val[4:0] = 5'(32'(width) + rand_word() % 32'(32 - width));
                    end
                    send("px_opa", load_enc(ca), rand_word());
                    send("px_opb", load_enc(cb), opb_val);
                    send($sformatf("packed_f%0d_pw%0d", f, p),
                         make_enc(4'(f), 3'(p), {1'b0, cd}, ca, cb, 16'd0), 32'd0);
                    send("px_readback", readback_enc(cd), 32'd0);
                end
            end
        end

        // Conditional moves with zero and nonzero conditions.
        for (int k = 0; k < 8; k++)
        begin
            send("cmov_src", load_enc(4'd1), rand_word());
            send("cmov_cond", load_enc(4'd2), k[0] ? (rand_word() | 32'd1) : 32'd0);
            send("cmov_dst", load_enc(4'd3), rand_word());
            send(k[1] ? "cmovn" : "cmov",
                 make_enc(k[1] ? FN_CMOVN : FN_CMOV, PW_32, 5'd3, 4'd1, 4'd2, 16'd0),
                 32'd0);
            send("cmov_readback", readback_enc(4'd3), 32'd0);
        end

        // Decode exceptions leave the target untouched.
        send("exc_setup", load_enc(4'd5), rand_word());
        for (int k = 0; k < 13; k++)
        begin
            enc = make_enc(FN_MV2COP, PW_32, 5'd5, 4'd0, 4'd0, 16'd0);
            if (k < 3)
                enc[6:0] = ISE_OPCODE ^ 7'(k + 1);
            else if (k < 9)
                enc[31:28] = 4'(k + 7);
            else
                enc = make_enc(4'(2 + k % 4), 3'(5 + k % 3), 5'd5, 4'd1, 4'd2, 16'd0);
            send("decode_exception", enc, rand_word());
            send("exc_readback", readback_enc(4'd5), 32'd0);
        end

        // Random mix under stalls and gaps.
        backpressure = 1'b1;
        gap_rate     = 30;
        for (int k = 0; k < 150; k++)
        begin
            enc        = rand_word();
            enc[31:28] = 4'(rand_word() % 32'd12);
            if ((rand_word() % 32'd8) != 32'd0)
                enc[6:0] = ISE_OPCODE;
            send("random_mix", enc, rand_word());
        end
        insn_valid   = 1'b0;
        backpressure = 1'b0;

        while (resp_count != sent_count)
            @(posedge g_clk);
        // A few idle cycles so a stray extra response would still be seen.
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        if (!resp_valid && insn_ready)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            report_failure("The pipeline did not return to idle after the last response");
        end
    end

endmodule

// File: verif/ise_assertions.sv
/* ISE response assertions */

module ise_assertions
    import ise_pkg::*;
(
    input logic      g_clk,
    input logic      ISE_RESET_CPRS,
    input ise_resp_t resp,
    input logic      resp_valid,
    input logic      resp_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // Response register is empty after reset.
    reset_clears_resp: assert property (
        @(posedge g_clk) ISE_RESET_CPRS |=> !resp_valid
    ) else $error("resp_valid is high in the cycle after reset");

    // A stalled response must hold.
    resp_holds: assert property (
        @(posedge g_clk) disable iff (ISE_RESET_CPRS)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
    ) else $error("Response dropped or changed while stalled");

    // Only two result codes exist in this design.
    result_known: assert property (
        @(posedge g_clk) disable iff (ISE_RESET_CPRS)
        resp_valid |-> (resp.result == RES_SUCCESS || resp.result == RES_DECODE_EXCEPTION)
    ) else $error("Response carries an unknown result code");

endmodule

bind ise_top ise_assertions assertions_inst (
    .g_clk          (g_clk),
    .ISE_RESET_CPRS (ISE_RESET_CPRS),
    .resp           (resp),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready)
);

// File: source/ise_top.sv
/* ISE coprocessor top */

module ise_top
    import ise_pkg::*;
(
    input  logic      g_clk,
    input  logic      ISE_RESET_CPRS,
    input  ise_insn_t insn,
    input  logic      insn_valid,
    output logic      insn_ready,
    output ise_resp_t resp,
    output logic      resp_valid,
    input  logic      resp_ready
);

    ise_decoded_t  dec;
    logic          dec_valid;
    logic          dec_ready;
    ise_cpr_addr_t cpr_raddr_a;
    ise_cpr_addr_t cpr_raddr_b;
    ise_cpr_addr_t cpr_raddr_d;
    ise_word_t     cpr_rdata_a;
    ise_word_t     cpr_rdata_b;
    ise_word_t     cpr_rdata_d;
    logic          cpr_wen;
    ise_cpr_addr_t cpr_waddr;
    ise_word_t     cpr_wdata;

    ise_decoder decoder_inst (
        .g_clk          (g_clk),
        .ISE_RESET_CPRS (ISE_RESET_CPRS),
        .insn           (insn),
        .insn_valid     (insn_valid),
        .insn_ready     (insn_ready),
        .dec            (dec),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready)
    );

    ise_execute execute_inst (
        .g_clk          (g_clk),
        .ISE_RESET_CPRS (ISE_RESET_CPRS),
        .dec            (dec),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .resp           (resp),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .cpr_raddr_a    (cpr_raddr_a),
        .cpr_raddr_b    (cpr_raddr_b),
        .cpr_raddr_d    (cpr_raddr_d),
        .cpr_rdata_a    (cpr_rdata_a),
        .cpr_rdata_b    (cpr_rdata_b),
        .cpr_rdata_d    (cpr_rdata_d),
        .cpr_wen        (cpr_wen),
        .cpr_waddr      (cpr_waddr),
        .cpr_wdata      (cpr_wdata)
    );

    ise_cpr_file cpr_file_inst (
        .g_clk          (g_clk),
        .ISE_RESET_CPRS (ISE_RESET_CPRS),
        .raddr_a        (cpr_raddr_a),
        .raddr_b        (cpr_raddr_b),
        .raddr_d        (cpr_raddr_d),
        .rdata_a        (cpr_rdata_a),
        .rdata_b        (cpr_rdata_b),
        .rdata_d        (cpr_rdata_d),
        .wen            (cpr_wen),
        .waddr          (cpr_waddr),
        .wdata          (cpr_wdata)
    );

endmodule

// File: source/ise_execute.sv
/* ISE execute stage */

module ise_execute
    import ise_pkg::*;
(
    input  logic          g_clk,
    input  logic          ISE_RESET_CPRS,
    input  ise_decoded_t  dec,
    input  logic          dec_valid,
    output logic          dec_ready,
    output ise_resp_t     resp,
    output logic          resp_valid,
    input  logic          resp_ready,
    output ise_cpr_addr_t cpr_raddr_a,
    output ise_cpr_addr_t cpr_raddr_b,
    output ise_cpr_addr_t cpr_raddr_d,
    input  ise_word_t     cpr_rdata_a,
    input  ise_word_t     cpr_rdata_b,
    input  ise_word_t     cpr_rdata_d,
    output logic          cpr_wen,
    output ise_cpr_addr_t cpr_waddr,
    output ise_word_t     cpr_wdata
);

    ise_word_t alu_result;
    ise_resp_t resp_next;
    logic      cpr_write;
    ise_word_t cpr_data;
    logic      fire;

    // Operands come straight from the decoded fields.
    assign cpr_raddr_a = dec.crs1;
    assign cpr_raddr_b = dec.crs2;
    assign cpr_raddr_d = dec.crd;

    ise_packed_alu alu_inst (
        .funct  (dec.funct),
        .pw     (dec.pw),
        .opa    (cpr_rdata_a),
        .opb    (cpr_rdata_b),
        .result (alu_result)
    );

    // ------------------------------
    // Result selection.
    // ------------------------------

    always_comb
    begin
        resp_next        = '0;
        resp_next.result = RES_SUCCESS;
        cpr_write        = 1'b0;
        cpr_data         = alu_result;
        if (dec.decode_exc)
        begin
            resp_next.result = RES_DECODE_EXCEPTION;
        end
        else
        begin
            case (dec.funct)
                FN_MV2GPR:
                begin
                    resp_next.gpr_wen  = 1'b1;
                    resp_next.gpr_addr = dec.rd;
                    resp_next.gpr_data = cpr_rdata_a;
                end
                FN_MV2COP:
                begin
                    cpr_write = 1'b1;
                    cpr_data  = dec.rs1;
                end
                FN_ADD_PX, FN_SUB_PX, FN_SLL_PX, FN_SRL_PX:
                    cpr_write = 1'b1;
                FN_CMOV:
                begin
                    cpr_write = (cpr_rdata_b == '0);
                    cpr_data  = cpr_rdata_a;
                end
                FN_CMOVN:
                begin
                    cpr_write = (cpr_rdata_b != '0);
                    cpr_data  = cpr_rdata_a;
                end
                FN_LUI:
                begin
                    cpr_write = 1'b1;
                    cpr_data  = {dec.imm, cpr_rdata_d[15:0]};
                end
                FN_LLI:
                begin
                    cpr_write = 1'b1;
                    cpr_data  = {cpr_rdata_d[31:16], dec.imm};
                end
                default:
                    cpr_write = 1'b0;
            endcase
        end
    end

    // ------------------------------
    // Response register.
    // ------------------------------

    assign dec_ready = !resp_valid || resp_ready;
    assign fire      = dec_valid && dec_ready;

    // CPR update commits together with the response load.
    assign cpr_wen   = fire && cpr_write;
    assign cpr_waddr = dec.crd;
    assign cpr_wdata = cpr_data;

    always_ff @(posedge g_clk)
    begin
        if (ISE_RESET_CPRS)
            resp_valid <= 1'b0;
        else if (dec_ready)
            resp_valid <= dec_valid;
    end

    always_ff @(posedge g_clk)
    begin
        if (fire)
            resp <= resp_next;
    end

endmodule

// File: source/ise_cpr_file.sv
/* ISE coprocessor registers */

module ise_cpr_file
    import ise_pkg::*;
(
    input  logic          g_clk,
    input  logic          ISE_RESET_CPRS,
    input  ise_cpr_addr_t raddr_a,
    input  ise_cpr_addr_t raddr_b,
    input  ise_cpr_addr_t raddr_d,
    output ise_word_t     rdata_a,
    output ise_word_t     rdata_b,
    output ise_word_t     rdata_d,
    input  logic          wen,
    input  ise_cpr_addr_t waddr,
    input  ise_word_t     wdata
);

    ise_word_t cprs [ISE_NUM_CPRS];

    // Whole file clears on reset.
    always_ff @(posedge g_clk)
    begin
        if (ISE_RESET_CPRS)
        begin
            for (int i = 0; i < ISE_NUM_CPRS; i++)
                cprs[i] <= '0;
        end
        else if (wen)
        begin
            cprs[waddr] <= wdata;
        end
    end

    // Asynchronous read ports.
    assign rdata_a = cprs[raddr_a];
    assign rdata_b = cprs[raddr_b];
    assign rdata_d = cprs[raddr_d];

endmodule

// File: source/ise_decoder.sv
/* ISE decode stage */

module ise_decoder
    import ise_pkg::*;
(
    input  logic         g_clk,
    input  logic         ISE_RESET_CPRS,
    input  ise_insn_t    insn,
    input  logic         insn_valid,
    output logic         insn_ready,
    output ise_decoded_t dec,
    output logic         dec_valid,
    input  logic         dec_ready
);

    ise_funct_t   funct;
    ise_pw_code_t pw;
    logic         opcode_ok;
    logic         funct_ok;
    logic         is_px;
    logic         pw_ok;
    ise_decoded_t dec_next;

    // ------------------------------
    // Field checks.
    // ------------------------------

    assign funct = insn.enc[31:28];
    assign pw    = {insn.enc[24], insn.enc[19], insn.enc[11]};

    assign opcode_ok = (insn.enc[6:0] == ISE_OPCODE);
    assign funct_ok  = (funct <= FN_LLI);

    // Only the packed instructions care about the width code.
    assign is_px = (funct == FN_ADD_PX) || (funct == FN_SUB_PX) ||
                   (funct == FN_SLL_PX) || (funct == FN_SRL_PX);
    assign pw_ok = !is_px || (pw <= PW_2);

    always_comb
    begin
        dec_next            = '0;
        dec_next.funct      = funct;
        dec_next.pw         = pw;
        dec_next.crd        = insn.enc[10:7];
        dec_next.rd         = insn.enc[11:7];
        dec_next.crs1       = insn.enc[18:15];
        dec_next.crs2       = insn.enc[23:20];
        dec_next.imm        = insn.enc[27:12];
        dec_next.rs1        = insn.rs1;
        dec_next.decode_exc = !(opcode_ok && funct_ok && pw_ok);
    end

    // ------------------------------
    // Stage register.
    // ------------------------------

    // Empty slot, or the held instruction leaves this cycle.
    assign insn_ready = !dec_valid || dec_ready;

    always_ff @(posedge g_clk)
    begin
        if (ISE_RESET_CPRS)
            dec_valid <= 1'b0;
        else if (insn_ready)
            dec_valid <= insn_valid;
    end

    always_ff @(posedge g_clk)
    begin
        if (insn_valid && insn_ready)
            dec <= dec_next;
    end

endmodule

// File: source/ise_packed_alu.sv
/* ISE packed ALU */

module ise_packed_alu
    import ise_pkg::*;
(
    input  ise_funct_t   funct,
    input  ise_pw_code_t pw,
    input  ise_word_t    opa,
    input  ise_word_t    opb,
    output ise_word_t    result
);

    logic [5:0] lane_w;
    logic [4:0] lane_mask;
    logic [4:0] amt;
    logic       is_sub;
    ise_word_t  sum;
    ise_word_t  shl;
    ise_word_t  shr;

    // Lane width halves with each step of the width code.
    assign lane_w    = 6'd32 >> pw;
    assign lane_mask = 5'(lane_w - 6'd1);
    assign amt       = opb[4:0];
    assign is_sub    = (funct == FN_SUB_PX);

    // ------------------------------
    // Lane-wise add and subtract.
    // ------------------------------

    // Ripple chain whose carry is replaced at each lane start.
    always_comb
    begin : p_addsub
        logic carry;
        logic cin;
        logic b_bit;
        carry = 1'b0;
        for (int i = 0; i < ISE_XLEN; i++)
        begin
            b_bit = opb[i] ^ is_sub;
            if ((5'(i) & lane_mask) == 5'd0)
                cin = is_sub;
            else
                cin = carry;
            sum[i] = opa[i] ^ b_bit ^ cin;
            carry  = (opa[i] & b_bit) | (cin & (opa[i] ^ b_bit));
        end
    end

    // ------------------------------
    // Lane-wise logical shifts.
    // ------------------------------

    // Shift the full word, then drop bits that crossed a lane edge.
    always_comb
    begin : p_shift
        ise_word_t  shl_raw;
        ise_word_t  shr_raw;
        logic [4:0] pos;
        shl_raw = opa << amt;
        shr_raw = opa >> amt;
        for (int i = 0; i < ISE_XLEN; i++)
        begin
            pos    = 5'(i) & lane_mask;
            shl[i] = (pos >= amt) ? shl_raw[i] : 1'b0;
            shr[i] = (({1'b0, pos} + {1'b0, amt}) < lane_w) ? shr_raw[i] : 1'b0;
        end
    end

    always_comb
    begin
        case (funct)
            FN_ADD_PX,
            FN_SUB_PX: result = sum;
            FN_SLL_PX: result = shl;
            FN_SRL_PX: result = shr;
            default:   result = '0;
        endcase
    end

endmodule

// File: source/ise_pkg.sv
/* ISE coprocessor shared definitions */

package ise_pkg;

    // ------------------------------
    // Widths.
    // ------------------------------

    localparam int ISE_XLEN     = 32;
    localparam int ISE_NUM_CPRS = 16;

    typedef logic [ISE_XLEN-1:0] ise_word_t;
    typedef logic [3:0]          ise_cpr_addr_t;
    typedef logic [4:0]          ise_gpr_addr_t;
    typedef logic [3:0]          ise_funct_t;
    typedef logic [2:0]          ise_pw_code_t;
    typedef logic [2:0]          ise_result_t;
    typedef logic [15:0]         ise_imm16_t;

    // ------------------------------
    // Encoding.
    // ------------------------------

    // Major opcode in encoding bits 6..0.
    localparam logic [6:0] ISE_OPCODE = 7'h2b;

    // Function codes from encoding bits 31..28.
    localparam ise_funct_t FN_MV2GPR = 4'd0;
    localparam ise_funct_t FN_MV2COP = 4'd1;
    localparam ise_funct_t FN_ADD_PX = 4'd2;
    localparam ise_funct_t FN_SUB_PX = 4'd3;
    localparam ise_funct_t FN_SLL_PX = 4'd4;
    localparam ise_funct_t FN_SRL_PX = 4'd5;
    localparam ise_funct_t FN_CMOV   = 4'd6;
    localparam ise_funct_t FN_CMOVN  = 4'd7;
    localparam ise_funct_t FN_LUI    = 4'd8;
    localparam ise_funct_t FN_LLI    = 4'd9;

    // Pack width codes, built from encoding bits {24, 19, 11}.
    localparam ise_pw_code_t PW_32 = 3'b000;
    localparam ise_pw_code_t PW_16 = 3'b001;
    localparam ise_pw_code_t PW_8  = 3'b010;
    localparam ise_pw_code_t PW_4  = 3'b011;
    localparam ise_pw_code_t PW_2  = 3'b100;

    // Instruction result codes.
    localparam ise_result_t RES_SUCCESS          = 3'b000;
    localparam ise_result_t RES_DECODE_EXCEPTION = 3'b010;

    // ------------------------------
    // Bundles.
    // ------------------------------

    typedef struct packed {
        ise_word_t enc;
        ise_word_t rs1;
    } ise_insn_t;

    typedef struct packed {
        ise_funct_t    funct;
        ise_pw_code_t  pw;
        ise_cpr_addr_t crd;
        ise_cpr_addr_t crs1;
        ise_cpr_addr_t crs2;
        ise_gpr_addr_t rd;
        ise_imm16_t    imm;
        ise_word_t     rs1;
        logic          decode_exc;
    } ise_decoded_t;

    typedef struct packed {
        ise_result_t   result;
        logic          gpr_wen;
        ise_gpr_addr_t gpr_addr;
        ise_word_t     gpr_data;
    } ise_resp_t;

endpackage
